// File: source/memPkg.sv
package memPkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------

    // One machine word
    parameter int WordSize = 32;

    // ----------------------------------------------------------------------
    // MIPS memory opcodes
    // ----------------------------------------------------------------------

    parameter logic [5:0] OpLb  = 6'h20;
    parameter logic [5:0] OpLh  = 6'h21;
    parameter logic [5:0] OpLw  = 6'h23;
    parameter logic [5:0] OpLbu = 6'h24;
    parameter logic [5:0] OpLhu = 6'h25;
    parameter logic [5:0] OpSh  = 6'h29;
    parameter logic [5:0] OpSw  = 6'h2b;

    // Decoded operation, MemNone for anything unknown
    typedef enum logic [2:0] {
        MemNone,
        MemLb,
        MemLbu,
        MemLh,
        MemLhu,
        MemLw,
        MemSh,
        MemSw
    } memOpT;

    // I-type layout of the instruction word
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] immediate;
    } instrT;

    // ----------------------------------------------------------------------
    // Stage structs
    // ----------------------------------------------------------------------

    // Decode to execute
    typedef struct packed {
        logic                valid;
        memOpT               op;
        logic                isLoad;
        logic                isStore;
        logic [15:0]         offset;
        logic [WordSize-1:0] baseValue;
        logic [WordSize-1:0] storeValue;
    } decodedT;

    // Execute to result, travels beside the memory read
    typedef struct packed {
        logic       valid;
        memOpT      op;
        logic [1:0] byteOffset;
    } accessT;

endpackage

// File: source/memory.sv
`timescale 1ns/10ps

module memory #(
    parameter int AddressSize = 10
)
(
    input  logic                         Clock,
    input  logic                         nReset,
    input  logic                         WriteEn,
    input  logic                         WriteL,
    input  logic                         WriteR,
    input  logic                         ReadEn,
    input  logic [AddressSize-1:0]       Address,
    input  logic [memPkg::WordSize-1:0]  WriteData,
    output logic [memPkg::WordSize-1:0]  ReadData
);

    // Number of bytes in the array
    localparam int Depth = 1 << AddressSize;

    // Byte storage, little-endian within a word
    logic [7:0] mem [0:Depth-1];

    // ----------------------------------------------------------------------
    // Write port
    // ----------------------------------------------------------------------

    // Whole array cleared on reset
    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            for (int i = 0; i < Depth; i++)
                mem[i] <= 8'h00;
        end
        else if (WriteEn)
        begin
            // Upper half lane
            if (WriteL)
            begin
                mem[Address + 3] <= WriteData[31:24];
                mem[Address + 2] <= WriteData[23:16];
            end
            // Lower half lane
            else if (WriteR)
            begin
                mem[Address + 1] <= WriteData[15:8];
                mem[Address]     <= WriteData[7:0];
            end
            // Full word
            else
            begin
                mem[Address + 3] <= WriteData[31:24];
                mem[Address + 2] <= WriteData[23:16];
                mem[Address + 1] <= WriteData[15:8];
                mem[Address]     <= WriteData[7:0];
            end
        end
    end

    // ----------------------------------------------------------------------
    // Read port
    // ----------------------------------------------------------------------

    // Registered read, zero when not enabled
    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
            ReadData <= '0;
        else if (ReadEn)
            ReadData <= {mem[Address + 3], mem[Address + 2], mem[Address + 1], mem[Address]};
        else
            ReadData <= '0;
    end

endmodule

// File: source/memDecode.sv
`timescale 1ns/10ps

module memDecode
(
    input  logic                         Clock,
    input  logic                         nReset,
    input  logic                         InstrValid,
    input  memPkg::instrT                Instr,
    input  logic [memPkg::WordSize-1:0]  BaseValue,
    input  logic [memPkg::WordSize-1:0]  StoreValue,
    output memPkg::decodedT              Decoded
);

    import memPkg::*;

    // Combinational classification
    memOpT               opNext;
    logic                isLoadNext;
    logic                isStoreNext;

    // Control registers
    logic                validQ;
    memOpT               opQ;
    logic                isLoadQ;
    logic                isStoreQ;

    // Operand registers
    logic [15:0]         offsetQ;
    logic [WordSize-1:0] baseQ;
    logic [WordSize-1:0] storeQ;

    // ----------------------------------------------------------------------
    // Opcode decode
    // ----------------------------------------------------------------------

    always_comb
    begin
        case (Instr.opcode)
            OpLb:    opNext = MemLb;
            OpLbu:   opNext = MemLbu;
            OpLh:    opNext = MemLh;
            OpLhu:   opNext = MemLhu;
            OpLw:    opNext = MemLw;
            OpSh:    opNext = MemSh;
            OpSw:    opNext = MemSw;
            // Unknown, flagged later by execute
            default: opNext = MemNone;
        endcase
    end

    // Load or store class
    assign isLoadNext  = (opNext == MemLb) || (opNext == MemLbu) || (opNext == MemLh) ||
                         (opNext == MemLhu) || (opNext == MemLw);
    assign isStoreNext = (opNext == MemSh) || (opNext == MemSw);

    // ----------------------------------------------------------------------
    // Pipeline register
    // ----------------------------------------------------------------------

    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            validQ   <= 1'b0;
            opQ      <= MemNone;
            isLoadQ  <= 1'b0;
            isStoreQ <= 1'b0;
        end
        else
        begin
            validQ   <= InstrValid;
            opQ      <= opNext;
            isLoadQ  <= isLoadNext;
            isStoreQ <= isStoreNext;
        end
    end

    // Operands only captured on a real instruction
    always_ff @(posedge Clock)
    begin
        if (InstrValid)
        begin
            offsetQ <= Instr.immediate;
            baseQ   <= BaseValue;
            storeQ  <= StoreValue;
        end
    end

    assign Decoded = '{valid: validQ, op: opQ, isLoad: isLoadQ, isStore: isStoreQ,
                       offset: offsetQ, baseValue: baseQ, storeValue: storeQ};

endmodule

// File: source/memExecute.sv
`timescale 1ns/10ps

module memExecute #(
    parameter int AddressSize = 10
)
(
    input  logic                         Clock,
    input  logic                         nReset,
    input  memPkg::decodedT              Decoded,
    output logic                         WriteEn,
    output logic                         WriteL,
    output logic                         WriteR,
    output logic                         ReadEn,
    output logic [AddressSize-1:0]       Address,
    output logic [memPkg::WordSize-1:0]  WriteData,
    output memPkg::accessT               Access,
    output logic                         AddressError
);

    import memPkg::*;

    // Address arithmetic
    logic [WordSize-1:0]    offsetExt;
    logic [WordSize-1:0]    effective;
    logic [AddressSize-1:0] byteAddress;

    // Legality
    logic                   aligned;
    logic                   legal;
    logic                   halfStore;

    // Access descriptor registers
    logic                   accessValidQ;
    memOpT                  accessOpQ;
    logic [1:0]             accessOffsetQ;

    // ----------------------------------------------------------------------
    // Effective address
    // ----------------------------------------------------------------------

    // Base plus sign-extended immediate
    assign offsetExt   = {{(WordSize-16){Decoded.offset[15]}}, Decoded.offset};
    assign effective   = Decoded.baseValue + offsetExt;
    assign byteAddress = effective[AddressSize-1:0];

    // Alignment per operation size
    always_comb
    begin
        case (Decoded.op)
            MemLw, MemSw:         aligned = (byteAddress[1:0] == 2'b00);
            MemLh, MemLhu, MemSh: aligned = ~byteAddress[0];
            MemLb, MemLbu:        aligned = 1'b1;
            // MemNone never legal
            default:              aligned = 1'b0;
        endcase
    end

    assign legal = Decoded.valid & aligned;

    // ----------------------------------------------------------------------
    // Memory drive
    // ----------------------------------------------------------------------

    assign ReadEn    = legal & Decoded.isLoad;
    assign WriteEn   = legal & Decoded.isStore;
    assign halfStore = (Decoded.op == MemSh);

    // Halfword lane from address bit 1
    assign WriteL = WriteEn & halfStore & byteAddress[1];
    assign WriteR = WriteEn & halfStore & ~byteAddress[1];

    // Word address into the array
    assign Address = {byteAddress[AddressSize-1:2], 2'b00};

    // Store data placed on its lane
    always_comb
    begin
        if (halfStore && byteAddress[1])
            WriteData = {Decoded.storeValue[15:0], 16'h0000};
        else if (halfStore)
            WriteData = {16'h0000, Decoded.storeValue[15:0]};
        else
            WriteData = Decoded.storeValue;
    end

    // ----------------------------------------------------------------------
    // Registered status, aligned with the memory read
    // ----------------------------------------------------------------------

    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            accessValidQ <= 1'b0;
            AddressError <= 1'b0;
        end
        else
        begin
            accessValidQ <= ReadEn;
            AddressError <= Decoded.valid & ~aligned;
        end
    end

    always_ff @(posedge Clock)
    begin
        accessOpQ     <= Decoded.op;
        accessOffsetQ <= byteAddress[1:0];
    end

    assign Access = '{valid: accessValidQ, op: accessOpQ, byteOffset: accessOffsetQ};

endmodule

// File: source/memResult.sv
`timescale 1ns/10ps

module memResult
(
    input  logic                         Clock,
    input  logic                         nReset,
    input  memPkg::accessT               Access,
    input  logic [memPkg::WordSize-1:0]  ReadData,
    output logic                         LoadValid,
    output logic [memPkg::WordSize-1:0]  LoadData
);

    import memPkg::*;

    // Selected pieces of the read word
    logic [7:0]          byteSel;
    logic [15:0]         halfSel;
    logic [WordSize-1:0] extended;

    // ----------------------------------------------------------------------
    // Lane select
    // ----------------------------------------------------------------------

    // Little-endian byte pick
    always_comb
    begin
        case (Access.byteOffset)
            2'd0:    byteSel = ReadData[7:0];
            2'd1:    byteSel = ReadData[15:8];
            2'd2:    byteSel = ReadData[23:16];
            default: byteSel = ReadData[31:24];
        endcase
    end

    // Halfword by address bit 1
    assign halfSel = Access.byteOffset[1] ? ReadData[31:16] : ReadData[15:0];

    // ----------------------------------------------------------------------
    // Extension
    // ----------------------------------------------------------------------

    always_comb
    begin
        case (Access.op)
            MemLb:   extended = {{(WordSize-8){byteSel[7]}}, byteSel};
            MemLbu:  extended = {{(WordSize-8){1'b0}}, byteSel};
            MemLh:   extended = {{(WordSize-16){halfSel[15]}}, halfSel};
            MemLhu:  extended = {{(WordSize-16){1'b0}}, halfSel};
            MemLw:   extended = ReadData;
            // Stores and errors carry no data
            default: extended = '0;
        endcase
    end

    // Output register, data held at zero between loads
    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            LoadValid <= 1'b0;
            LoadData  <= '0;
        end
        else
        begin
            LoadValid <= Access.valid;
            LoadData  <= Access.valid ? extended : '0;
        end
    end

endmodule

// File: source/loadStoreUnit.sv
`timescale 1ns/10ps

module loadStoreUnit #(
    parameter int AddressSize = 10
)
(
    input  logic                         Clock,
    input  logic                         nReset,
    input  logic                         InstrValid,
    input  memPkg::instrT                Instr,
    input  logic [memPkg::WordSize-1:0]  BaseValue,
    input  logic [memPkg::WordSize-1:0]  StoreValue,
    output logic                         LoadValid,
    output logic                         AddressError,
    output logic [memPkg::WordSize-1:0]  LoadData
);

    import memPkg::*;

    // Decode to execute
    decodedT                decoded;

    // Execute to memory
    logic                   writeEn;
    logic                   writeL;
    logic                   writeR;
    logic                   readEn;
    logic [AddressSize-1:0] address;
    logic [WordSize-1:0]    writeData;

    // Memory and execute to result
    logic [WordSize-1:0]    readData;
    accessT                 access;

    // ----------------------------------------------------------------------
    // Pipeline
    // ----------------------------------------------------------------------

    memDecode decodeStage (
        .Clock      (Clock),
        .nReset     (nReset),
        .InstrValid (InstrValid),
        .Instr      (Instr),
        .BaseValue  (BaseValue),
        .StoreValue (StoreValue),
        .Decoded    (decoded)
    );

    memExecute #(.AddressSize(AddressSize)) executeStage (
        .Clock        (Clock),
        .nReset       (nReset),
        .Decoded      (decoded),
        .WriteEn      (writeEn),
        .WriteL       (writeL),
        .WriteR       (writeR),
        .ReadEn       (readEn),
        .Address      (address),
        .WriteData    (writeData),
        .Access       (access),
        .AddressError (AddressError)
    );

    // Data memory, read lands with the access descriptor
    memory #(.AddressSize(AddressSize)) dataMemory (
        .Clock     (Clock),
        .nReset    (nReset),
        .WriteEn   (writeEn),
        .WriteL    (writeL),
        .WriteR    (writeR),
        .ReadEn    (readEn),
        .Address   (address),
        .WriteData (writeData),
        .ReadData  (readData)
    );

    memResult resultStage (
        .Clock     (Clock),
        .nReset    (nReset),
        .Access    (access),
        .ReadData  (readData),
        .LoadValid (LoadValid),
        .LoadData  (LoadData)
    );

endmodule

// File: verif/loadStoreUnitTb.sv
`timescale 1ns/10ps

module loadStoreUnitTb;

    import memPkg::*;

    localparam int AddressSize   = 10;
    localparam int Depth         = 1 << AddressSize;
    localparam int LoadLatency   = 3;
    localparam int ErrorLatency  = 2;
    localparam int StrobeTimeout = 10;
    localparam int IssueTimeout  = 400;

    // One row of the stimulus table
    typedef struct {
        string       name;
        logic [5:0]  opcode;
        logic [31:0] base;
        logic [15:0] offset;
        logic [31:0] storeValue;
        int          gap;
        logic        expLoad;
        logic [31:0] expData;
        logic        expError;
    } stepT;

    // DUT ports
    logic                Clock;
    logic                nReset;
    logic                InstrValid;
    instrT               Instr;
    logic [WordSize-1:0] BaseValue;
    logic [WordSize-1:0] StoreValue;
    logic                LoadValid;
    logic                AddressError;
    logic [WordSize-1:0] LoadData;

    // Table, issue times and reference memory
    stepT                steps[$];
    int                  issueCycle[];
    logic [7:0]          refMem [0:Depth-1];

    // Bookkeeping
    int                  cycleCount;
    int                  errorCount;
    int                  loadPulses;
    int                  errorPulses;
    int unsigned         seedValue;

    loadStoreUnit #(.AddressSize(AddressSize)) dut (
        .Clock        (Clock),
        .nReset       (nReset),
        .InstrValid   (InstrValid),
        .Instr        (Instr),
        .BaseValue    (BaseValue),
        .StoreValue   (StoreValue),
        .LoadValid    (LoadValid),
        .AddressError (AddressError),
        .LoadData     (LoadData)
    );

    // 40 ns clock
    always #20 Clock = ~Clock;

    always @(posedge Clock)
        cycleCount <= cycleCount + 1;

    // Strobe counts and idle data sampled mid-cycle
    always @(negedge Clock)
    begin
        if (nReset)
        begin
            if (LoadValid)
                loadPulses++;
            if (AddressError)
                errorPulses++;
            if (!LoadValid && LoadData !== '0)
            begin
                $display("[FAIL] idle LoadData at cycle %0d: expected %h actual %h",
                         cycleCount, 32'h0000_0000, LoadData);
                errorCount++;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Table and reference model
    // ----------------------------------------------------------------------

    task automatic addStep(string name, logic [5:0] opcode, logic [31:0] base,
                           logic [15:0] offset, logic [31:0] storeValue, int gap);
        stepT s;
        s = '{name: name, opcode: opcode, base: base, offset: offset,
              storeValue: storeValue, gap: gap, expLoad: 1'b0, expData: '0, expError: 1'b0};
        steps.push_back(s);
    endtask

    // Little-endian byte model applied in program order
    function automatic void predict(int idx);
        stepT        s;
        logic [31:0] effective;
        int          addr;
        logic        aligned;
        logic        isLoad;
        s = steps[idx];
        effective = s.base + {{16{s.offset[15]}}, s.offset};
        addr = int'(effective[AddressSize-1:0]);
        isLoad = s.opcode inside {OpLb, OpLbu, OpLh, OpLhu, OpLw};
        case (s.opcode)
            OpLw, OpSw:        aligned = (addr % 4 == 0);
            OpLh, OpLhu, OpSh: aligned = (addr % 2 == 0);
            OpLb, OpLbu:       aligned = 1'b1;
            default:           aligned = 1'b0;
        endcase
        s.expError = !aligned;
        s.expLoad  = aligned && isLoad;
        s.expData  = '0;
        if (aligned)
        begin
            case (s.opcode)
                OpSw:
                begin
                    for (int k = 0; k < 4; k++)
                        refMem[addr + k] = s.storeValue[8*k +: 8];
                end
                OpSh:
                begin
                    refMem[addr]     = s.storeValue[7:0];
                    refMem[addr + 1] = s.storeValue[15:8];
                end
                OpLw:    s.expData = {refMem[addr + 3], refMem[addr + 2],
                                      refMem[addr + 1], refMem[addr]};
                OpLh:    s.expData = {{16{refMem[addr + 1][7]}}, refMem[addr + 1], refMem[addr]};
                OpLhu:   s.expData = {16'h0000, refMem[addr + 1], refMem[addr]};
                OpLb:    s.expData = {{24{refMem[addr][7]}}, refMem[addr]};
                OpLbu:   s.expData = {24'h000000, refMem[addr]};
                default: s.expData = '0;
            endcase
        end
        steps[idx] = s;
    endfunction

    task automatic buildTable();
        logic [31:0] word [0:12];
        for (int k = 0; k <= 12; k++)
            word[k] = $urandom();
        // Fresh memory spaced out to see idle strobes
        addStep("lw idle 0x000", OpLw, 32'h000, 16'h0000, '0, 3);
        addStep("lw idle 0x1f0", OpLw, 32'h1e0, 16'h0010, '0, 3);
        addStep("lw idle 0x3fc", OpLw, 32'h3fc, 16'h0000, '0, 3);
        // Word store and load with negative offset
        addStep("sw 0x040", OpSw, 32'h040, 16'h0000, word[0], 1);
        addStep("lw 0x040", OpLw, 32'h040, 16'h0000, '0, 1);
        addStep("sw 0x084", OpSw, 32'h080, 16'h0004, word[1], 1);
        addStep("lw 0x084 negative offset", OpLw, 32'h090, 16'hfff4, '0, 1);
        addStep("lw 0x080 untouched", OpLw, 32'h080, 16'h0000, '0, 1);
        // Halfword lanes
        addStep("sw 0x100", OpSw, 32'h100, 16'h0000, word[2], 1);
        addStep("sh upper 0x102", OpSh, 32'h100, 16'h0002, word[3] | 32'h8000, 1);
        addStep("lw 0x100 after sh", OpLw, 32'h100, 16'h0000, '0, 1);
        addStep("lh 0x102", OpLh, 32'h100, 16'h0002, '0, 1);
        addStep("lhu 0x102", OpLhu, 32'h100, 16'h0002, '0, 1);
        addStep("sw 0x108", OpSw, 32'h108, 16'h0000, word[4], 1);
        addStep("sh lower 0x108", OpSh, 32'h108, 16'h0000, word[5] & 32'hffff_7fff, 1);
        addStep("lw 0x108 after sh", OpLw, 32'h108, 16'h0000, '0, 1);
        addStep("lh 0x108", OpLh, 32'h108, 16'h0000, '0, 1);
        addStep("lhu 0x108", OpLhu, 32'h108, 16'h0000, '0, 1);
        // Bytes with the top bit set in every lane
        addStep("sw 0x200", OpSw, 32'h200, 16'h0000, word[6] | 32'h8080_8080, 1);
        for (int k = 0; k < 4; k++)
        begin
            addStep($sformatf("lb 0x20%0d", k), OpLb, 32'h200, 16'(k), '0, 1);
            addStep($sformatf("lbu 0x20%0d", k), OpLbu, 32'h200, 16'(k), '0, 1);
        end
        addStep("sw 0x204", OpSw, 32'h204, 16'h0000, word[7] & 32'h7f7f_7f7f, 1);
        addStep("lb 0x205 positive", OpLb, 32'h204, 16'h0001, '0, 1);
        // Misaligned and unknown
        addStep("lw misaligned 0x041", OpLw, 32'h040, 16'h0001, '0, 1);
        addStep("sw misaligned 0x042", OpSw, 32'h040, 16'h0002, word[8], 1);
        addStep("lw 0x040 after bad sw", OpLw, 32'h040, 16'h0000, '0, 1);
        addStep("lh misaligned 0x101", OpLh, 32'h100, 16'h0001, '0, 1);
        addStep("sh misaligned 0x103", OpSh, 32'h100, 16'h0003, word[9], 1);
        addStep("unknown opcode", 6'h3f, 32'h100, 16'h0000, '0, 1);
        addStep("lw 0x100 after bad sh", OpLw, 32'h100, 16'h0000, '0, 1);
        // Back-to-back burst
        addStep("burst sw 0x300", OpSw, 32'h300, 16'h0000, word[10], 0);
        addStep("burst sw 0x304", OpSw, 32'h300, 16'h0004, word[11], 0);
        addStep("burst lw 0x304", OpLw, 32'h304, 16'h0000, '0, 0);
        addStep("burst lw 0x300", OpLw, 32'h300, 16'h0000, '0, 0);
        addStep("burst lh misaligned 0x305", OpLh, 32'h300, 16'h0005, '0, 0);
        addStep("burst sh 0x302", OpSh, 32'h300, 16'h0002, word[12], 0);
        addStep("burst lw 0x300 after sh", OpLw, 32'h300, 16'h0000, '0, 0);
        addStep("burst lb 0x303", OpLb, 32'h300, 16'h0003, '0, 0);
        addStep("burst lhu 0x306", OpLhu, 32'h304, 16'h0002, '0, 0);
        addStep("burst lw 0x3fc", OpLw, 32'h3fc, 16'h0000, '0, 0);
    endtask

    // ----------------------------------------------------------------------
    // Drive and check
    // ----------------------------------------------------------------------

    task automatic driveSteps();
        for (int i = 0; i < steps.size(); i++)
        begin
            @(posedge Clock);
            #2;
            InstrValid    = 1'b1;
            Instr         = '{opcode: steps[i].opcode, rs: 5'd4, rt: 5'd5,
                              immediate: steps[i].offset};
            BaseValue     = steps[i].base;
            StoreValue    = steps[i].storeValue;
            issueCycle[i] = cycleCount;
            // Idle cycles after this one
            for (int g = 0; g < steps[i].gap; g++)
            begin
                @(posedge Clock);
                #2;
                InstrValid = 1'b0;
            end
        end
        @(posedge Clock);
        #2;
        InstrValid = 1'b0;
    endtask

    // Waits for one strobe per expected event in table order
    task automatic checkStrobes(bit forLoads);
        int   waited;
        logic seen;
        for (int i = 0; i < steps.size(); i++)
        begin
            if (forLoads ? steps[i].expLoad : steps[i].expError)
            begin
                waited = 0;
                while (issueCycle[i] < 0 && waited < IssueTimeout)
                begin
                    @(negedge Clock);
                    waited++;
                end
                if (issueCycle[i] < 0)
                begin
                    $display("%s was never issued", steps[i].name);
                    errorCount++;
                end
                else
                begin
                    waited = 0;
                    do
                    begin
                        @(negedge Clock);
                        waited++;
                        seen = forLoads ? LoadValid : AddressError;
                    end
                    while (!seen && waited < StrobeTimeout);
                    if (!seen)
                    begin
                        $display("%s: no %s within %0d cycles", steps[i].name,
                                 forLoads ? "LoadValid" : "AddressError", StrobeTimeout);
                        errorCount++;
                    end
                    else
                    begin
                        if (cycleCount - issueCycle[i] != (forLoads ? LoadLatency : ErrorLatency))
                        begin
                            $display("[FAIL] %s latency: expected %0d actual %0d", steps[i].name,
                                     forLoads ? LoadLatency : ErrorLatency,
                                     cycleCount - issueCycle[i]);
                            errorCount++;
                        end
                        if (forLoads && LoadData !== steps[i].expData)
                        begin
                            $display("[FAIL] %s: expected %h actual %h", steps[i].name,
                                     steps[i].expData, LoadData);
                            errorCount++;
                        end
                    end
                end
            end
        end
    endtask

    initial
    begin
        int expectedLoads;
        int expectedErrors;
        Clock       = 1'b0;
        nReset      = 1'b0;
        InstrValid  = 1'b0;
        Instr       = '0;
        BaseValue   = '0;
        StoreValue  = '0;
        cycleCount  = 0;
        errorCount  = 0;
        loadPulses  = 0;
        errorPulses = 0;
        seedValue   = 32'h8780_8ca5;
        void'($urandom(seedValue));

        // Model starts from the cleared memory
        for (int a = 0; a < Depth; a++)
            refMem[a] = 8'h00;
        buildTable();
        issueCycle = new[steps.size()];
        expectedLoads  = 0;
        expectedErrors = 0;
        for (int i = 0; i < steps.size(); i++)
        begin
            issueCycle[i] = -1;
            predict(i);
            if (steps[i].expLoad)
                expectedLoads++;
            if (steps[i].expError)
                expectedErrors++;
        end

        repeat (10) @(posedge Clock);
        #2;
        nReset = 1'b1;

        fork
            driveSteps();
            checkStrobes(1'b1);
            checkStrobes(1'b0);
        join

        // Let the pipeline drain before counting strobes
        repeat (6) @(negedge Clock);
        if (loadPulses != expectedLoads)
        begin
            $display("[FAIL] load strobe count: expected %0d actual %0d", expectedLoads,
                     loadPulses);
            errorCount++;
        end
        if (errorPulses != expectedErrors)
        begin
            $display("[FAIL] error strobe count: expected %0d actual %0d", expectedErrors,
                     errorPulses);
            errorCount++;
        end

        $display("Summary: %0d loads, %0d address errors, %0d mismatches",
                 loadPulses, errorPulses, errorCount);
        if (errorCount == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: sim.f
source/memPkg.sv
source/memory.sv
source/memDecode.sv
source/memExecute.sv
source/memResult.sv
source/loadStoreUnit.sv
verif/loadStoreUnitTb.sv
